// File: Bender.yml
package:
  name: board_top

sources:
  - board_pkg.sv
  - video_if.sv
  - board_reset.sv
  - frame_latch.sv
  - board_inputs.sv
  - board_dip.sv
  - video_bw_filter.sv
  - video_out.sv
  - board_top.sv
  - target: test
    files:
      - tb_board_top.sv

// File: board_dip.sv
// OSD status word and core mode decoding into registered DIP settings
`timescale 1ns/1ps

module board_dip (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic [31:0] status,
    input  logic [1:0]  core_mod,
    input  logic        game_pause,
    output logic        osd_pause,
    output logic        bw_en,
    output logic [1:0]  rotate,
    output logic        dip_flip,
    output logic        dip_test,
    output logic        dip_pause,
    output logic [1:0]  dip_fxlevel,
    output logic        enable_fm,
    output logic        enable_psg
);

    import board_pkg::*;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            osd_pause   <= 1'b0;
            bw_en       <= 1'b0;
            rotate      <= 2'b00;
            dip_flip    <= 1'b0;
            dip_test    <= 1'b0;
            // Active low, so not paused
            dip_pause   <= 1'b1;
            dip_fxlevel <= 2'b00;
            enable_fm   <= 1'b0;
            enable_psg  <= 1'b0;
        end else begin
            // Vertical games only honour the OSD rotate option
            rotate      <= {status[ST_ROT_BIT] & core_mod[0], core_mod[0]};
            dip_flip    <= status[ST_FLIP_BIT] ^ core_mod[1];
            dip_test    <= status[ST_TEST_BIT];
            osd_pause   <= status[ST_PAUSE_BIT];
            enable_fm   <= ~status[ST_FM_OFF_BIT];
            enable_psg  <= ~status[ST_PSG_OFF_BIT];
            dip_fxlevel <= status[ST_FX_LSB +: 2];
            bw_en       <= status[ST_BW_BIT];
            dip_pause   <= ~game_pause;
        end
    end

endmodule

// File: board_inputs.sv
// Player input polarity, frame latching, pause toggle and soft reset key
`timescale 1ns/1ps

module board_inputs #(
    parameter int ACTIVE_LOW = 1
) (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      lvbl,
    input  logic [15:0]               board_joy1,
    input  logic [15:0]               board_joy2,
    input  logic [1:0]                board_coin,
    input  logic [1:0]                board_start,
    input  logic                      key_service,
    input  logic                      key_pause,
    input  logic                      key_reset,
    input  logic                      osd_pause,
    output logic [board_pkg::JOYW-1:0] game_joy1,
    output logic [board_pkg::JOYW-1:0] game_joy2,
    output logic [1:0]                game_coin,
    output logic [1:0]                game_start,
    output logic                      game_service,
    output logic                      game_pause,
    output logic                      soft_rst
);

    import board_pkg::*;

    localparam logic INV = ACTIVE_LOW != 0;

    player_joy_t joy_d;
    player_joy_t joy_init;
    player_joy_t joy_q;
    coin_start_t cs_d;
    coin_start_t cs_init;
    coin_start_t cs_q;
    logic        key_pause_l;
    logic        key_reset_l;
    logic        pause_st;

    // Board side is active high, game side takes the selected polarity
    assign joy_d[0] = board_joy1[JOYW-1:0] ^ {JOYW{INV}};
    assign joy_d[1] = board_joy2[JOYW-1:0] ^ {JOYW{INV}};
    assign joy_init = {(2 * JOYW){INV}};

    assign cs_d = '{
        coin:    board_coin ^ {2{INV}},
        start:   board_start ^ {2{INV}},
        service: key_service ^ INV
    };
    assign cs_init = {$bits(coin_start_t){INV}};

    frame_latch #(.payload_t(player_joy_t)) u_joy_latch (
        .clk_sys (clk_sys),
        .reset   (reset),
        .lvbl    (lvbl),
        .d       (joy_d),
        .init    (joy_init),
        .q       (joy_q)
    );

    frame_latch #(.payload_t(coin_start_t)) u_cs_latch (
        .clk_sys (clk_sys),
        .reset   (reset),
        .lvbl    (lvbl),
        .d       (cs_d),
        .init    (cs_init),
        .q       (cs_q)
    );

    assign game_joy1    = joy_q[0];
    assign game_joy2    = joy_q[1];
    assign game_coin    = cs_q.coin;
    assign game_start   = cs_q.start;
    assign game_service = cs_q.service;

    // Key edge detection
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            key_pause_l <= 1'b0;
            key_reset_l <= 1'b0;
            pause_st    <= 1'b0;
            soft_rst    <= 1'b0;
        end else begin
            key_pause_l <= key_pause;
            key_reset_l <= key_reset;
            soft_rst    <= key_reset & ~key_reset_l;
            if (key_pause && !key_pause_l) begin
                pause_st <= ~pause_st;
            end
        end
    end

    // Either the key toggle or the OSD can hold the game
    assign game_pause = pause_st | osd_pause;

endmodule

// File: board_pkg.sv
// Board package with input widths, payload types and OSD status bit positions
package board_pkg;

    // One game joystick word, buttons and directions
    localparam int JOYW = 10;

    // Output colour width after extension
    localparam int OUT_COLW = 8;

    // Two players, index 0 is player one
    typedef logic [1:0][JOYW-1:0] player_joy_t;

    typedef struct packed {
        logic [1:0] coin;
        logic [1:0] start;
        logic       service;
    } coin_start_t;

    // OSD status word bit positions
    localparam int ST_ROT_BIT     = 2;
    localparam int ST_FLIP_BIT    = 3;
    localparam int ST_TEST_BIT    = 4;
    localparam int ST_PAUSE_BIT   = 5;
    localparam int ST_FM_OFF_BIT  = 6;
    localparam int ST_PSG_OFF_BIT = 7;
    // FX level, 2 bits wide
    localparam int ST_FX_LSB      = 8;
    localparam int ST_BW_BIT      = 10;

endpackage

// File: board_reset.sv
// System and game reset generation with a release delay counter for each
`timescale 1ns/1ps

module board_reset #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk_sys,
    input  logic reset,
    input  logic rst_req,
    input  logic pll_locked,
    input  logic downloading,
    input  logic soft_rst,
    output logic rst,
    output logic game_rst
);

    localparam int CW = $clog2(RST_CYCLES + 1);

    logic [CW-1:0] sys_cnt;
    logic [CW-1:0] game_cnt;
    logic          sys_cause;
    logic          game_cause;

    assign sys_cause  = reset | rst_req | ~pll_locked;
    // Game side also follows the system reset
    assign game_cause = sys_cause | rst | downloading | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (sys_cause) begin
            sys_cnt <= CW'(RST_CYCLES);
        end else if (sys_cnt != '0) begin
            sys_cnt <= sys_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (game_cause) begin
            game_cnt <= CW'(RST_CYCLES);
        end else if (game_cnt != '0) begin
            game_cnt <= game_cnt - 1'b1;
        end
    end

    assign rst      = sys_cnt != '0;
    assign game_rst = game_cnt != '0;

    // Game logic must never run while the system is held in reset
    a_game_covers_sys: assert property (@(posedge clk_sys) rst |-> game_rst)
        else $error("game_rst low while rst high");

endmodule

// File: board_top.sv
// Arcade board wrapper top with reset, player inputs, DIP decoding and video path
`timescale 1ns/1ps

module board_top #(
    parameter int COLORW     = 4,
    parameter int ACTIVE_LOW = 1,
    parameter int RST_CYCLES = 16
) (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  logic                          rst_req,
    input  logic                          pll_locked,
    input  logic                          downloading,
    output logic                          rst,
    output logic                          game_rst,
    // Player inputs
    input  logic [15:0]                   board_joy1,
    input  logic [15:0]                   board_joy2,
    input  logic [1:0]                    board_coin,
    input  logic [1:0]                    board_start,
    input  logic                          key_service,
    input  logic                          key_pause,
    input  logic                          key_reset,
    output logic [board_pkg::JOYW-1:0]     game_joy1,
    output logic [board_pkg::JOYW-1:0]     game_joy2,
    output logic [1:0]                    game_coin,
    output logic [1:0]                    game_start,
    output logic                          game_service,
    output logic                          game_pause,
    output logic                          soft_rst,
    // OSD and DIP settings
    input  logic [31:0]                   status,
    input  logic [1:0]                    core_mod,
    output logic [1:0]                    rotate,
    output logic                          dip_flip,
    output logic                          dip_test,
    output logic                          dip_pause,
    output logic [1:0]                    dip_fxlevel,
    output logic                          enable_fm,
    output logic                          enable_psg,
    // Game video
    input  logic                          pxl_cen,
    input  logic                          hs,
    input  logic                          vs,
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic [COLORW-1:0]             r,
    input  logic [COLORW-1:0]             g,
    input  logic [COLORW-1:0]             b,
    output logic [board_pkg::OUT_COLW-1:0] video_r,
    output logic [board_pkg::OUT_COLW-1:0] video_g,
    output logic [board_pkg::OUT_COLW-1:0] video_b,
    output logic                          video_hs,
    output logic                          video_vs,
    output logic                          video_de,
    output logic                          video_cen
);

    logic osd_pause;
    logic bw_en;

    video_if #(.W(COLORW + 1)) vid ();

    board_reset #(.RST_CYCLES(RST_CYCLES)) u_reset (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .rst_req     (rst_req),
        .pll_locked  (pll_locked),
        .downloading (downloading),
        .soft_rst    (soft_rst),
        .rst         (rst),
        .game_rst    (game_rst)
    );

    board_inputs #(.ACTIVE_LOW(ACTIVE_LOW)) u_inputs (
        .clk_sys      (clk_sys),
        .reset        (rst),
        .lvbl         (lvbl),
        .board_joy1   (board_joy1),
        .board_joy2   (board_joy2),
        .board_coin   (board_coin),
        .board_start  (board_start),
        .key_service  (key_service),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .osd_pause    (osd_pause),
        .game_joy1    (game_joy1),
        .game_joy2    (game_joy2),
        .game_coin    (game_coin),
        .game_start   (game_start),
        .game_service (game_service),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst)
    );

    board_dip u_dip (
        .clk_sys     (clk_sys),
        .reset       (rst),
        .status      (status),
        .core_mod    (core_mod),
        .game_pause  (game_pause),
        .osd_pause   (osd_pause),
        .bw_en       (bw_en),
        .rotate      (rotate),
        .dip_flip    (dip_flip),
        .dip_test    (dip_test),
        .dip_pause   (dip_pause),
        .dip_fxlevel (dip_fxlevel),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg)
    );

    video_bw_filter #(.COLORW(COLORW)) u_bw_filter (
        .clk_sys (clk_sys),
        .reset   (rst),
        .pxl_cen (pxl_cen),
        .bw_en   (bw_en),
        .hs      (hs),
        .vs      (vs),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .r       (r),
        .g       (g),
        .b       (b),
        .vid     (vid.src)
    );

    video_out #(.COLORW(COLORW)) u_video_out (
        .clk_sys (clk_sys),
        .reset   (rst),
        .vid     (vid.dst),
        .out_r   (video_r),
        .out_g   (video_g),
        .out_b   (video_b),
        .out_hs  (video_hs),
        .out_vs  (video_vs),
        .out_de  (video_de),
        .out_cen (video_cen)
    );

endmodule

// File: files.f
board_pkg.sv
video_if.sv
board_reset.sv
frame_latch.sv
board_inputs.sv
board_dip.sv
video_bw_filter.sv
video_out.sv
board_top.sv
tb_board_top.sv

// File: frame_latch.sv
// Payload register loaded once per frame at the start of vertical blank
`timescale 1ns/1ps

module frame_latch #(
    parameter type payload_t = logic
) (
    input  logic     clk_sys,
    input  logic     reset,
    input  logic     lvbl,
    input  payload_t d,
    input  payload_t init,
    output payload_t q
);

    logic lvbl_l;
    logic blank_start;

    // lvbl is active low, so a falling edge starts the blank
    assign blank_start = ~lvbl & lvbl_l;

    always_ff @(posedge clk_sys) begin
        lvbl_l <= lvbl;
        if (reset) begin
            q <= init;
        end else if (blank_start) begin
            q <= d;
        end
    end

    a_hold_in_frame: assert property (@(posedge clk_sys)
        !$past(blank_start) && !$past(reset) |-> $stable(q))
        else $error("frame latch output changed outside blank start");

endmodule

// File: tb_board_top.sv
// Testbench for the arcade board wrapper, random stimulus checked against a model
`timescale 1ns/1ps

module tb_board_top;

    import board_pkg::*;

    localparam int COLORW     = 4;
    localparam int ACTIVE_LOW = 1;
    localparam int RST_CYCLES = 16;
    localparam int SEED       = 83254;
    // Five tests of at most 3000 cycles each plus margin
    localparam int MAX_CYCLES = 20000;
    localparam logic [31:0] INACT = (ACTIVE_LOW != 0) ? '1 : '0;

    logic                clk_sys;
    logic                reset;
    logic                rst_req;
    logic                pll_locked;
    logic                downloading;
    logic                rst;
    logic                game_rst;
    logic [15:0]         board_joy1;
    logic [15:0]         board_joy2;
    logic [1:0]          board_coin;
    logic [1:0]          board_start;
    logic                key_service;
    logic                key_pause;
    logic                key_reset;
    logic [JOYW-1:0]     game_joy1;
    logic [JOYW-1:0]     game_joy2;
    logic [1:0]          game_coin;
    logic [1:0]          game_start;
    logic                game_service;
    logic                game_pause;
    logic                soft_rst;
    logic [31:0]         status;
    logic [1:0]          core_mod;
    logic [1:0]          rotate;
    logic                dip_flip;
    logic                dip_test;
    logic                dip_pause;
    logic [1:0]          dip_fxlevel;
    logic                enable_fm;
    logic                enable_psg;
    logic                pxl_cen;
    logic                hs;
    logic                vs;
    logic                lhbl;
    logic                lvbl;
    logic [COLORW-1:0]   r;
    logic [COLORW-1:0]   g;
    logic [COLORW-1:0]   b;
    logic [OUT_COLW-1:0] video_r;
    logic [OUT_COLW-1:0] video_g;
    logic [OUT_COLW-1:0] video_b;
    logic                video_hs;
    logic                video_vs;
    logic                video_de;
    logic                video_cen;

    // Model state and shadows of the driven inputs
    logic [15:0]         j1_sh;
    logic [15:0]         j2_sh;
    logic [1:0]          coin_sh;
    logic [1:0]          start_sh;
    logic                svc_sh;
    logic                lvbl_sh;
    logic [24:0]         exp_cur;
    logic [24:0]         exp_pend;
    logic [31:0]         st;
    logic                m_pause;
    logic [COLORW-1:0]   pr;
    logic [COLORW-1:0]   pg;
    logic [COLORW-1:0]   pb;
    logic [COLORW:0]     fr;
    logic [COLORW:0]     fg;
    logic [COLORW:0]     fb;
    logic                fde;
    logic                fhs;
    logic                fvs;

    int cycles;
    int checks;
    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;

    board_top DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - errors_at_start;
        if (n == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, n);
        end
        errors_at_start = errors;
    endtask

    // Levels expected while the sub-blocks sit in reset
    task automatic inactive_levels();
        compare("game_joy1", game_joy1, INACT[JOYW-1:0]);
        compare("game_joy2", game_joy2, INACT[JOYW-1:0]);
        compare("game_coin", game_coin, INACT[1:0]);
        compare("game_start", game_start, INACT[1:0]);
        compare("game_service", game_service, INACT[0]);
        compare("dip_pause", dip_pause, 1);
        compare("soft_rst", soft_rst, 0);
        compare("game_pause", game_pause, 0);
        compare("rotate", rotate, 0);
        compare("dip_flip", dip_flip, 0);
        compare("dip_test", dip_test, 0);
        compare("dip_fxlevel", dip_fxlevel, 0);
        compare("enable_fm", enable_fm, 0);
        compare("enable_psg", enable_psg, 0);
        compare("video_r", video_r, 0);
        compare("video_g", video_g, 0);
        compare("video_b", video_b, 0);
        compare("video_hs", video_hs, 0);
        compare("video_vs", video_vs, 0);
        compare("video_de", video_de, 0);
        compare("video_cen", video_cen, 0);
    endtask

    // Counts edges until the chosen reset goes low
    task automatic wait_release(input bit use_game, input string name);
        int n;
        bit done;
        n = 0;
        done = 1'b0;
        while (!done && n < 4 * RST_CYCLES) begin
            @(posedge clk_sys);
            n++;
            @(negedge clk_sys);
            done = use_game ? !game_rst : !rst;
        end
        checks++;
        assert (done) else begin
            $display("%s stayed high for %0d cycles after its causes cleared", name, n);
            errors++;
        end
        if (done) begin
            checks++;
            assert (n >= RST_CYCLES && n <= RST_CYCLES + 1) else begin
                $display("ERROR at %0t ns: %s released after %0d cycles, expected %0d to %0d",
                         $time, name, n, RST_CYCLES, RST_CYCLES + 1);
                errors++;
            end
        end
    endtask

    // 0 is rst_req, 1 is PLL unlock, 2 is a ROM download
    task automatic pulse_cause(input int which);
        int hold;
        hold = rand_range(3, 10);
        @(posedge clk_sys);
        case (which)
            0: rst_req <= 1'b1;
            1: pll_locked <= 1'b0;
            default: downloading <= 1'b1;
        endcase
        repeat (hold) @(posedge clk_sys);
        @(negedge clk_sys);
        if (which == 2) begin
            compare("rst", rst, 0);
            compare("game_rst", game_rst, 1);
        end else begin
            compare("rst", rst, 1);
            compare("game_rst", game_rst, 1);
            inactive_levels();
        end
        @(posedge clk_sys);
        rst_req     <= 1'b0;
        pll_locked  <= 1'b1;
        downloading <= 1'b0;
        if (which != 2) begin
            wait_release(1'b0, "rst");
        end
        wait_release(1'b1, "game_rst");
    endtask

    function automatic logic [24:0] capture_inputs();
        logic [24:0] raw;
        raw = {j2_sh[JOYW-1:0], j1_sh[JOYW-1:0], coin_sh, start_sh, svc_sh};
        return (ACTIVE_LOW != 0) ? ~raw : raw;
    endfunction

    // One clock of the latching test where the latch loads on the edge after lvbl falls
    task automatic input_cycle(input logic new_lvbl);
        @(posedge clk_sys);
        exp_cur = exp_pend;
        if ($urandom % 4 == 0) begin
            j1_sh    = $urandom;
            j2_sh    = $urandom;
            coin_sh  = $urandom;
            start_sh = $urandom;
            svc_sh   = $urandom;
        end
        board_joy1  <= j1_sh;
        board_joy2  <= j2_sh;
        board_coin  <= coin_sh;
        board_start <= start_sh;
        key_service <= svc_sh;
        lvbl        <= new_lvbl;
        if (lvbl_sh && !new_lvbl) begin
            exp_pend = capture_inputs();
        end
        lvbl_sh = new_lvbl;
        @(negedge clk_sys);
        compare("game_joy2", game_joy2, exp_cur[24:15]);
        compare("game_joy1", game_joy1, exp_cur[14:5]);
        compare("game_coin", game_coin, exp_cur[4:3]);
        compare("game_start", game_start, exp_cur[2:1]);
        compare("game_service", game_service, exp_cur[0]);
    endtask

    function automatic logic [COLORW:0] filter_mix(input logic [COLORW-1:0] cur,
                                                   input logic [COLORW-1:0] prev,
                                                   input logic bw);
        if (bw) begin
            return cur + prev;
        end
        return cur + cur;
    endfunction

    // Repeated copies of the value with the top bits kept
    function automatic logic [OUT_COLW-1:0] widen(input logic [COLORW:0] v);
        logic [4*(COLORW+1)-1:0] rep;
        rep = {4{v}};
        return rep[4*(COLORW+1)-1 -: OUT_COLW];
    endfunction

    // Two clocks per pixel while the output shows the pixel before this one
    task automatic video_pixel(input logic bw);
        logic [COLORW-1:0] xr;
        logic [COLORW-1:0] xg;
        logic [COLORW-1:0] xb;
        logic              hb;
        logic              vb;
        logic              xhs;
        logic              xvs;
        logic [COLORW:0]   nr;
        logic [COLORW:0]   ng;
        logic [COLORW:0]   nb;
        @(posedge clk_sys);
        xr = $urandom;
        xg = $urandom;
        xb = $urandom;
        hb = ($urandom % 8) != 0;
        vb = ($urandom % 16) != 0;
        xhs = $urandom % 2;
        xvs = $urandom % 2;
        pxl_cen <= 1'b1;
        r       <= xr;
        g       <= xg;
        b       <= xb;
        lhbl    <= hb;
        lvbl    <= vb;
        hs      <= xhs;
        vs      <= xvs;
        nr = filter_mix(xr, pr, bw);
        ng = filter_mix(xg, pg, bw);
        nb = filter_mix(xb, pb, bw);
        @(negedge clk_sys);
        compare("video_cen", video_cen, 0);
        @(posedge clk_sys);
        pxl_cen <= 1'b0;
        @(negedge clk_sys);
        compare("video_r", video_r, widen(fr));
        compare("video_g", video_g, widen(fg));
        compare("video_b", video_b, widen(fb));
        compare("video_hs", video_hs, fhs);
        compare("video_vs", video_vs, fvs);
        compare("video_de", video_de, fde);
        compare("video_cen", video_cen, 1);
        fr  = nr;
        fg  = ng;
        fb  = nb;
        fde = hb & vb;
        fhs = xhs;
        fvs = xvs;
        pr  = xr;
        pg  = xg;
        pb  = xb;
    endtask

    initial begin
        logic [1:0] cm;
        int         act;
        int         blk;
        void'($urandom(SEED));
        reset = 1'b1;
        rst_req = 1'b0;
        pll_locked = 1'b1;
        downloading = 1'b0;
        board_joy1 = '0;
        board_joy2 = '0;
        board_coin = '0;
        board_start = '0;
        key_service = 1'b0;
        key_pause = 1'b0;
        key_reset = 1'b0;
        status = '0;
        core_mod = '0;
        pxl_cen = 1'b0;
        hs = 1'b0;
        vs = 1'b0;
        lhbl = 1'b0;
        lvbl = 1'b1;
        r = '0;
        g = '0;
        b = '0;
        {j1_sh, j2_sh, coin_sh, start_sh, svc_sh} = '0;
        lvbl_sh = 1'b1;
        exp_pend = INACT[24:0];
        st = '0;
        m_pause = 1'b0;
        {pr, pg, pb, fr, fg, fb, fde, fhs, fvs} = '0;

        // Test 1 covers reset sources and release timing
        repeat (5) @(posedge clk_sys);
        reset <= 1'b0;
        @(negedge clk_sys);
        compare("rst", rst, 1);
        compare("game_rst", game_rst, 1);
        inactive_levels();
        wait_release(1'b0, "rst");
        wait_release(1'b1, "game_rst");
        for (int i = 0; i < 6; i++) begin
            pulse_cause(i % 3);
        end
        end_test("1 reset");

        // Test 2 covers DIP decoding
        for (int i = 0; i < 200; i++) begin
            @(posedge clk_sys);
            st = $urandom;
            cm = $urandom;
            status   <= st;
            core_mod <= cm;
            repeat (2) @(posedge clk_sys);
            @(negedge clk_sys);
            compare("rotate", rotate, {st[ST_ROT_BIT] & cm[0], cm[0]});
            compare("dip_flip", dip_flip, st[ST_FLIP_BIT] ^ cm[1]);
            compare("dip_test", dip_test, st[ST_TEST_BIT]);
            compare("enable_fm", enable_fm, !st[ST_FM_OFF_BIT]);
            compare("enable_psg", enable_psg, !st[ST_PSG_OFF_BIT]);
            compare("dip_fxlevel", dip_fxlevel, st[ST_FX_LSB +: 2]);
            compare("game_pause", game_pause, m_pause | st[ST_PAUSE_BIT]);
            compare("dip_pause", dip_pause, !(m_pause | st[ST_PAUSE_BIT]));
        end
        end_test("2 dip decoding");

        // Test 3 covers frame latching of player inputs
        for (int f = 0; f < 10; f++) begin
            act = rand_range(15, 50);
            blk = rand_range(3, 8);
            for (int c = 0; c < act + blk; c++) begin
                input_cycle(c < act);
            end
        end
        end_test("3 input latching");

        // Test 4 covers the pause toggle with OSD pause and then soft reset
        for (int i = 0; i < 20; i++) begin
            repeat (rand_range(0, 6)) @(posedge clk_sys);
            @(posedge clk_sys);
            st[ST_PAUSE_BIT] = $urandom % 2;
            status    <= st;
            key_pause <= 1'b1;
            m_pause = !m_pause;
            @(posedge clk_sys);
            key_pause <= 1'b0;
            repeat (3) @(posedge clk_sys);
            @(negedge clk_sys);
            compare("game_pause", game_pause, m_pause | st[ST_PAUSE_BIT]);
            compare("dip_pause", dip_pause, !(m_pause | st[ST_PAUSE_BIT]));
        end
        for (int i = 0; i < 3; i++) begin
            repeat (rand_range(2, 8)) @(posedge clk_sys);
            @(posedge clk_sys);
            key_reset <= 1'b1;
            @(posedge clk_sys);
            key_reset <= 1'b0;
            @(negedge clk_sys);
            compare("soft_rst", soft_rst, 1);
            @(posedge clk_sys);
            @(negedge clk_sys);
            compare("game_rst", game_rst, 1);
            compare("rst", rst, 0);
            compare("soft_rst", soft_rst, 0);
            wait_release(1'b1, "game_rst");
        end
        end_test("4 pause and soft reset");

        // Test 5 covers the colour filter and output extension
        for (int run = 0; run < 6; run++) begin
            @(posedge clk_sys);
            st[ST_BW_BIT] = (run % 2) == 0;
            status <= st;
            repeat (3) @(posedge clk_sys);
            repeat (40) video_pixel(st[ST_BW_BIT]);
        end
        end_test("5 video");

        $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: video_bw_filter.sv
// Colour bandwidth filter, averages neighbouring pixels and adds one bit
`timescale 1ns/1ps

module video_bw_filter #(
    parameter int COLORW = 4
) (
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              pxl_cen,
    input  logic              bw_en,
    input  logic              hs,
    input  logic              vs,
    input  logic              lhbl,
    input  logic              lvbl,
    input  logic [COLORW-1:0] r,
    input  logic [COLORW-1:0] g,
    input  logic [COLORW-1:0] b,
    video_if.src              vid
);

    logic [COLORW-1:0] r_l;
    logic [COLORW-1:0] g_l;
    logic [COLORW-1:0] b_l;

    // Sum of two samples, or the current one doubled to keep the scale
    function automatic logic [COLORW:0] bw_mix(
        input logic [COLORW-1:0] cur,
        input logic [COLORW-1:0] prev,
        input logic              en
    );
        return en ? ({1'b0, cur} + {1'b0, prev}) : {cur, 1'b0};
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            r_l      <= '0;
            g_l      <= '0;
            b_l      <= '0;
            vid.r    <= '0;
            vid.g    <= '0;
            vid.b    <= '0;
            vid.hs   <= 1'b0;
            vid.vs   <= 1'b0;
            vid.lhbl <= 1'b0;
            vid.lvbl <= 1'b0;
        end else if (pxl_cen) begin
            r_l      <= r;
            g_l      <= g;
            b_l      <= b;
            vid.r    <= bw_mix(r, r_l, bw_en);
            vid.g    <= bw_mix(g, g_l, bw_en);
            vid.b    <= bw_mix(b, b_l, bw_en);
            // Sync and blank stay aligned with the filtered colour
            vid.hs   <= hs;
            vid.vs   <= vs;
            vid.lhbl <= lhbl;
            vid.lvbl <= lvbl;
        end
    end

    assign vid.cen = pxl_cen;

endmodule

// File: video_if.sv
// Pixel stream bundle with colour, sync, blanking and pixel clock enable
`timescale 1ns/1ps

interface video_if #(
    parameter int W = 5
) ();

    logic [W-1:0] r;
    logic [W-1:0] g;
    logic [W-1:0] b;
    logic         hs;
    logic         vs;
    logic         lhbl;
    logic         lvbl;
    // Pixel valid on cycles with cen high
    logic         cen;

    modport src (output r, g, b, hs, vs, lhbl, lvbl, cen);

    modport dst (input r, g, b, hs, vs, lhbl, lvbl, cen);

endinterface

// File: video_out.sv
// Colour extension to 8 bits and data enable for the video output
`timescale 1ns/1ps

module video_out #(
    parameter int COLORW = 4
) (
    input  logic                          clk_sys,
    input  logic                          reset,
    video_if.dst                          vid,
    output logic [board_pkg::OUT_COLW-1:0] out_r,
    output logic [board_pkg::OUT_COLW-1:0] out_g,
    output logic [board_pkg::OUT_COLW-1:0] out_b,
    output logic                          out_hs,
    output logic                          out_vs,
    output logic                          out_de,
    output logic                          out_cen
);

    import board_pkg::*;

    // Filtered colour carries one extra bit
    localparam int CW = COLORW + 1;

    logic lvbl_r;

    // Repeat the value from the MSB down until the output is full
    function automatic logic [OUT_COLW-1:0] extend8(input logic [CW-1:0] a);
        logic [OUT_COLW-1:0] v;
        for (int i = 0; i < OUT_COLW; i++) begin
            v[OUT_COLW-1-i] = a[CW-1-(i % CW)];
        end
        return v;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            out_r   <= '0;
            out_g   <= '0;
            out_b   <= '0;
            out_hs  <= 1'b0;
            out_vs  <= 1'b0;
            out_de  <= 1'b0;
            lvbl_r  <= 1'b0;
            out_cen <= 1'b0;
        end else begin
            out_cen <= vid.cen;
            if (vid.cen) begin
                out_r  <= extend8(vid.r);
                out_g  <= extend8(vid.g);
                out_b  <= extend8(vid.b);
                out_hs <= vid.hs;
                out_vs <= vid.vs;
                out_de <= vid.lhbl & vid.lvbl;
                lvbl_r <= vid.lvbl;
            end
        end
    end

    a_de_in_active: assert property (@(posedge clk_sys) disable iff (reset)
        out_de |-> lvbl_r)
        else $error("out_de high during vertical blank");

endmodule
